//--- isa_pkg.sv
package isa_pkg;

	// 16-bit instruction set, eight general registers

	// Register number
	typedef logic [2:0] reg_idx_t;

	// Opcode field, top five bits of the word
	// NOP must stay at zero so an all-zero word decodes as a no-op
	typedef enum logic [4:0] {
		NOP  = 5'd0,
		ADD  = 5'd1,
		ADDI = 5'd2,
		LD   = 5'd3,
		ST   = 5'd4,
		J    = 5'd5
	} opcode_t;

	// Instruction word layout, MSB first
	//   [15:11] opcode
	//   [10:8]  rs
	//   [7:5]   rt
	//   [4:2]   rd
	//   [1:0]   spare
	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		logic [1:0]  spare;
	} instr_t;

	// Register use per opcode
	//   ADD   reads rs, rt    writes rd
	//   ADDI  reads rs        writes rt
	//   LD    reads rs        writes rt, memory load
	//   ST    reads rs (addr), rt (data), memory store
	//   J     no register use
	//   NOP   no register use
	// Immediates and jump targets are not modelled here

	// Empty slot content
	localparam instr_t INSTR_NOP = 16'h0000;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// Decoded view of the instruction sitting in IF/ID
	// Filled by the decoder, read by the hazard unit and the tracker
	typedef struct packed {
		// Slot holds a real instruction
		logic      valid;
		// Raw source fields
		reg_idx_t  rs;
		reg_idx_t  rt;
		// Which source fields are really read
		logic      rs_used;
		logic      rt_used;
		// Store in ID, needed for load-to-store exemption
		logic      is_store;
		// Register write and its target
		logic      reg_write;
		reg_idx_t  dest;
		// Data memory access
		logic      mem_en;
		logic      mem_write;
	} id_ctrl_t;

	// Record carried down ID/EX, EX/MEM and MEM/WB
	// Only what the hazard check and retire port need
	typedef struct packed {
		logic      valid;
		logic      reg_write;
		reg_idx_t  dest;
		// Load is mem_en with mem_write low
		logic      mem_en;
		logic      mem_write;
	} stage_rec_t;

	// Empty stage, also the bubble pushed into ID/EX on stall
	localparam stage_rec_t STAGE_BUBBLE = '0;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  instr_t   instr,
	input  logic     valid,
	output id_ctrl_t id_ctrl
);

	// Pure decode of the IF/ID word, no state
	always_comb begin
		id_ctrl = '0;
		id_ctrl.valid = valid;
		// Fields always passed on, use flags decide whether they count
		id_ctrl.rs = instr.rs;
		id_ctrl.rt = instr.rt;

		// Empty slot reads and writes nothing
		if (valid) begin
			case (instr.opcode)
				ADD: begin
					id_ctrl.rs_used   = 1'b1;
					id_ctrl.rt_used   = 1'b1;
					id_ctrl.reg_write = 1'b1;
					// R-type result goes to rd
					id_ctrl.dest      = instr.rd;
				end
				ADDI: begin
					// rt is the target here, not a source
					id_ctrl.rs_used   = 1'b1;
					id_ctrl.reg_write = 1'b1;
					id_ctrl.dest      = instr.rt;
				end
				LD: begin
					// Address from rs, loaded value into rt
					id_ctrl.rs_used   = 1'b1;
					id_ctrl.reg_write = 1'b1;
					id_ctrl.dest      = instr.rt;
					id_ctrl.mem_en    = 1'b1;
				end
				ST: begin
					// rs is the address, rt the data
					id_ctrl.rs_used   = 1'b1;
					id_ctrl.rt_used   = 1'b1;
					id_ctrl.is_store  = 1'b1;
					id_ctrl.mem_en    = 1'b1;
					id_ctrl.mem_write = 1'b1;
				end
				// J and NOP touch no register
				default: begin
					id_ctrl.rs_used   = 1'b0;
					id_ctrl.rt_used   = 1'b0;
				end
			endcase
		end
	end

endmodule

//--- hazard_detector.sv
`timescale 1ns/1ps

module hazard_detector
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter bit MEMWB_CHECK = 1'b0
) (
	input  id_ctrl_t   id_ctrl,
	input  stage_rec_t id_ex_rec,
	input  stage_rec_t ex_mem_rec,
	input  stage_rec_t mem_wb_rec,
	output logic       stall,
	output logic       pc_write_en,
	output logic       if_id_write_en
);

	// Stage record writes the given register
	function automatic logic writes_reg(stage_rec_t rec, reg_idx_t r);
		return rec.valid && rec.reg_write && (rec.dest == r);
	endfunction

	// Raw matches, masked by whether ID really reads the field
	logic id_ex_raw_rs, id_ex_raw_rt;
	logic ex_mem_raw_rs, ex_mem_raw_rt;
	logic mem_wb_raw_rs, mem_wb_raw_rt;
	// Per-stage stall terms
	logic id_ex_stall, ex_mem_stall, mem_wb_stall;
	// Load in EX/MEM feeding store data in ID
	logic ld_to_st;

	assign id_ex_raw_rs  = id_ctrl.rs_used && writes_reg(id_ex_rec, id_ctrl.rs);
	assign id_ex_raw_rt  = id_ctrl.rt_used && writes_reg(id_ex_rec, id_ctrl.rt);
	assign ex_mem_raw_rs = id_ctrl.rs_used && writes_reg(ex_mem_rec, id_ctrl.rs);
	assign ex_mem_raw_rt = id_ctrl.rt_used && writes_reg(ex_mem_rec, id_ctrl.rt);
	assign mem_wb_raw_rs = id_ctrl.rs_used && writes_reg(mem_wb_rec, id_ctrl.rs);
	assign mem_wb_raw_rt = id_ctrl.rt_used && writes_reg(mem_wb_rec, id_ctrl.rt);

	// Load data reaches the store through the memory-stage bypass
	assign ld_to_st = ex_mem_rec.mem_en && !ex_mem_rec.mem_write && id_ctrl.is_store;

	assign id_ex_stall  = id_ex_raw_rs || id_ex_raw_rt;
	// Address operand from the load still has to wait
	assign ex_mem_stall = ex_mem_raw_rs || (ex_mem_raw_rt && !ld_to_st);
	// Normally covered by bypassing, only checked when asked for
	assign mem_wb_stall = MEMWB_CHECK && (mem_wb_raw_rs || mem_wb_raw_rt);

	assign stall = id_ctrl.valid && (id_ex_stall || ex_mem_stall || mem_wb_stall);

	// PC and IF/ID freeze together
	assign pc_write_en    = !stall;
	assign if_id_write_en = !stall;

endmodule

//--- pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  instr_t     fetch_instr,
	input  logic       fetch_valid,
	input  logic       stall,
	input  id_ctrl_t   id_ctrl,
	output instr_t     if_id_instr,
	output logic       if_id_valid,
	output stage_rec_t id_ex_rec,
	output stage_rec_t ex_mem_rec,
	output stage_rec_t mem_wb_rec
);

	// Record leaving ID this cycle
	stage_rec_t id_ex_next;

	always_comb begin
		id_ex_next = STAGE_BUBBLE;
		// Stalled instruction stays in ID, a bubble goes down instead
		if (!stall) begin
			id_ex_next.valid     = id_ctrl.valid;
			id_ex_next.reg_write = id_ctrl.reg_write;
			id_ex_next.dest      = id_ctrl.dest;
			id_ex_next.mem_en    = id_ctrl.mem_en;
			id_ex_next.mem_write = id_ctrl.mem_write;
		end
	end

	// IF/ID, written only when not stalled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id_instr <= INSTR_NOP;
			if_id_valid <= 1'b0;
		end else if (!stall) begin
			// Empty fetch leaves a NOP word behind
			if_id_instr <= fetch_valid ? fetch_instr : INSTR_NOP;
			if_id_valid <= fetch_valid;
		end
	end

	// ID/EX takes decoded record or bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex_rec <= STAGE_BUBBLE;
		end else begin
			id_ex_rec <= id_ex_next;
		end
	end

	// Later stages shift every cycle, stall does not reach them
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_rec <= STAGE_BUBBLE;
			mem_wb_rec <= STAGE_BUBBLE;
		end else begin
			ex_mem_rec <= id_ex_rec;
			mem_wb_rec <= ex_mem_rec;
		end
	end

endmodule

//--- hazard_front_top.sv
`timescale 1ns/1ps

module hazard_front_top
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter bit MEMWB_CHECK = 1'b0
) (
	input  logic     clk,
	input  logic     arst_n,
	input  instr_t   fetch_instr,
	input  logic     fetch_valid,
	output logic     stall,
	output logic     pc_write_en,
	output logic     if_id_write_en,
	output logic     retire_valid,
	output logic     retire_reg_write,
	output reg_idx_t retire_dest
);

	// IF/ID contents
	instr_t     if_id_instr;
	logic       if_id_valid;
	// Decoded ID slot
	id_ctrl_t   id_ctrl;
	// Downstream stage records
	stage_rec_t id_ex_rec, ex_mem_rec, mem_wb_rec;

	pipe_tracker u_tracker (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_instr (fetch_instr),
		.fetch_valid (fetch_valid),
		.stall       (stall),
		.id_ctrl     (id_ctrl),
		.if_id_instr (if_id_instr),
		.if_id_valid (if_id_valid),
		.id_ex_rec   (id_ex_rec),
		.ex_mem_rec  (ex_mem_rec),
		.mem_wb_rec  (mem_wb_rec)
	);

	instr_decoder u_decoder (
		.instr   (if_id_instr),
		.valid   (if_id_valid),
		.id_ctrl (id_ctrl)
	);

	hazard_detector #(
		.MEMWB_CHECK (MEMWB_CHECK)
	) u_hazard (
		.id_ctrl        (id_ctrl),
		.id_ex_rec      (id_ex_rec),
		.ex_mem_rec     (ex_mem_rec),
		.mem_wb_rec     (mem_wb_rec),
		.stall          (stall),
		.pc_write_en    (pc_write_en),
		.if_id_write_en (if_id_write_en)
	);

	// Retire port is the MEM/WB record
	assign retire_valid     = mem_wb_rec.valid;
	assign retire_reg_write = mem_wb_rec.reg_write;
	assign retire_dest      = mem_wb_rec.dest;

endmodule

//--- tb_hazard_front.sv
`timescale 1ns/1ps

module tb_hazard_front
	import isa_pkg::*;
;

	logic     clk;
	logic     arst_n;
	instr_t   fetch_instr;
	logic     fetch_valid;
	logic     stall;
	logic     pc_write_en;
	logic     if_id_write_en;
	logic     retire_valid;
	logic     retire_reg_write;
	reg_idx_t retire_dest;

	// Golden program and per-entry results
	logic [15:0] words[$];
	int          exp_stall[$];
	int          seen_stall[64];
	// Expected retire {reg_write, dest} in program order
	logic [3:0]  exp_q[$];
	int          n_entries;
	int          last_idx;
	int          retired;
	int          err_cnt;
	int          cycles;
	int          cycle_limit = 1000000;

	hazard_front_top dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.fetch_instr      (fetch_instr),
		.fetch_valid      (fetch_valid),
		.stall            (stall),
		.pc_write_en      (pc_write_en),
		.if_id_write_en   (if_id_write_en),
		.retire_valid     (retire_valid),
		.retire_reg_write (retire_reg_write),
		.retire_dest      (retire_dest)
	);

	always #5 clk = !clk;

	// Register write per opcode from the ISA table
	function automatic logic [3:0] retire_from_word(logic [15:0] w);
		logic [4:0] op;
		op = w[15:11];
		case (op)
			ADD: return {1'b1, w[4:2]};
			ADDI, LD: return {1'b1, w[7:5]};
			default: return 4'b0000;
		endcase
	endfunction

	task automatic load_golden();
		int    fd;
		int    word;
		int    cnt;
		string line;
		fd = $fopen("hazard_front_golden.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("Could not open hazard_front_golden.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				// Skip column notes and blank lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%h %d", word, cnt) == 2) begin
						words.push_back(word[15:0]);
						exp_stall.push_back(cnt);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Hard stop on a hung pipeline
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Run stopped after %0d cycles without all instructions retiring", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Sample mid-cycle where outputs have settled
	always @(negedge clk) begin
		if (arst_n) begin
			assert (pc_write_en == !stall && if_id_write_en == !stall) else begin
				err_cnt++;
				$display("ERR %0t: write enables %b/%b with stall %b", $time,
					pc_write_en, if_id_write_en, stall);
			end
			// Stall belongs to whatever sits in ID
			if (stall && last_idx >= 0)
				seen_stall[last_idx]++;
			if (retire_valid) begin
				assert (exp_q.size() > 0) else begin
					err_cnt++;
					$display("Retire seen with no accepted instruction outstanding");
				end
				if (exp_q.size() > 0) begin
					assert (retire_reg_write == exp_q[0][3] &&
						(!exp_q[0][3] || retire_dest == exp_q[0][2:0])) else begin
						err_cnt++;
						$display("ERR %0t: retire %b/r%0d, expected %b/r%0d", $time,
							retire_reg_write, retire_dest, exp_q[0][3], exp_q[0][2:0]);
					end
					void'(exp_q.pop_front());
				end
				retired++;
			end
			// Acceptance happens at the coming edge
			if (fetch_valid && pc_write_en) begin
				last_idx++;
				exp_q.push_back(retire_from_word(words[last_idx]));
			end
		end
	end

	initial begin
		int gap;
		clk = 1'b0;
		arst_n = 1'b0;
		fetch_instr = INSTR_NOP;
		fetch_valid = 1'b0;
		last_idx = -1;
		retired = 0;
		err_cnt = 0;
		cycles = 0;
		void'($urandom(32'hbd14));
		load_golden();
		n_entries = words.size();
		cycle_limit = 4 * n_entries + 100;
		assert (n_entries > 0) else begin
			err_cnt++;
			$display("No instructions read from hazard_front_golden.txt");
		end

		repeat (16) @(posedge clk);
		#1 arst_n = 1'b1;
		@(negedge clk);
		assert (!stall && !retire_valid && pc_write_en && if_id_write_en) else begin
			err_cnt++;
			$display("ERR %0t: outputs wrong after reset", $time);
		end

		for (int i = 0; i < n_entries; i++) begin
			// Idle only where no stall count nearby can shrink
			gap = 0;
			if (exp_stall[i] == 0 && (i == n_entries - 1 || exp_stall[i + 1] == 0))
				gap = int'($urandom % 3);
			@(posedge clk);
			#1;
			fetch_valid = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			fetch_valid = 1'b1;
			fetch_instr = instr_t'(words[i]);
			// Word held until an edge with pc_write_en high
			do
				@(negedge clk);
			while (!pc_write_en);
		end
		@(posedge clk);
		#1 fetch_valid = 1'b0;

		while (retired < n_entries)
			@(posedge clk);
		@(negedge clk);

		for (int i = 0; i < n_entries; i++) begin
			assert (seen_stall[i] == exp_stall[i]) else begin
				err_cnt++;
				$display("ERR %0t: entry %0d (%h) stalled %0d, expected %0d", $time,
					i, words[i], seen_stall[i], exp_stall[i]);
			end
		end
		assert (exp_q.size() == 0 && retired == n_entries) else begin
			err_cnt++;
			$display("Retire count %0d does not match %0d accepted", retired, n_entries);
		end

		$display("Checked %0d instructions, %0d errors", n_entries, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- hazard_front_golden.txt
# columns: instruction word (hex), expected stall cycles (decimal)
# rest of a line is a remark
0A64 0 ADD r1 = r2 + r3
1580 0 ADDI r4 from r5
0F18 0 ADD r6 = r7 + r0
1020 0 ADDI r1 from r0
0908 2 ADD r2 = r1 + r0, r1 one back
1060 0 ADDI r3 from r0
2800 0 J
0B14 1 ADD r5 = r3 + r0, r3 two back
10E0 0 ADDI r7 from r0
0000 0 NOP
2800 0 J
0FF8 0 ADD r6 = r7 + r7, r7 three back
1860 0 LD r3 from [r0]
2060 1 ST r3 to [r0], load feeds data
0000 0 NOP
1880 0 LD r4 from [r0]
2400 2 ST r0 to [r4], load feeds address
10A0 0 ADDI r5 from r0
10A0 0 ADDI r5 again, rt is only a target
2DA0 0 J with r5 in both fields
05A0 0 NOP with r5 in both fields
1820 0 LD r1 from [r0]
0828 2 ADD r2 = r0 + r1, load into ALU
2800 0 J
2040 1 ST r2 to [r0], r2 two back
10C0 0 ADDI r6 from r0

//--- hazard_front.f
isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
hazard_detector.sv
pipe_tracker.sv
hazard_front_top.sv
tb_hazard_front.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the hazard front testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_hazard_front \
	-f hazard_front.f \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" <<< "$out"; then
	exit 0
fi
exit 1
